/* nora_trace_tests.dat */
# cyc c02 addr data pins(mx,sync,mln,vpn,vda,ef,rwn) mx_after run | clr
# rd idx sel | cnt count ; all fields hex, run 0 before rd, cnt or clr
cnt 0
cyc 0 1234 56 3d 1 0
rd 0 0
rd 0 1
rd 0 2
rd 0 3
rd 0 4
cyc 0 abcd 12 7e 0 1
cyc 1 4321 9a 18 0 1
cyc 1 0200 ea 01 0 1
cyc 0 fffc 00 35 0 1
cyc 0 1000 01 3f 0 1
cyc 0 1001 02 3d 1 1
cyc 0 1002 03 3d 0 1
cyc 0 1003 04 5d 1 0
cnt 8
rd 0 0
rd 3 4
rd 5 0
rd 7 2
rd 1 5
rd 2 7
clr
cnt 0
rd 0 1
cyc 1 beef 77 2a 1 0
cnt 1
rd 0 0
rd 0 3
rd 1 0

/* files.f */
cpu_bus_pkg.sv
trace_pkg.sv
phaser.sv
cpu_bus_sampler.sv
trace_buffer.sv
nora_trace_top.sv
phaser_checker.sv
tb_nora_trace.sv

/* Makefile */
sim:
	verilator --binary --timing -f files.f --top-module tb_nora_trace --Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* tb_nora_trace.sv */
// ~~~~~~~~~~~~~~~~~~~~
// testbench for nora_trace_top, file driven, with trace model
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_nora_trace;
    import cpu_bus_pkg::*;
    import trace_pkg::*;

    logic         clk6x = 1'b0;
    logic         rst_n_i;
    logic         run_i;
    logic         cputype02_i;
    logic         trace_clr_i;
    cpu_addr_t    cpu_ab_i;
    cpu_data_t    cd_i;
    cpu_pins_t    pins_i;
    trace_idx_t   trace_idx_i;
    byte_sel_t    trace_byte_sel_i;
    logic         cphi2_o;
    logic         stopped_o;
    cpu_data_t    trace_byte_o;
    trace_cnt_t   trace_count_o;

    trace_entry_t model_q[$];       // newest at the front
    int           errors = 0;
    int           checks = 0;
    int           cycles = 0;
    int           cycle_limit = 0;  // 0 until the test file is sized

    nora_trace_top DUT (.*);

    initial
    begin
        forever #20 clk6x = ~clk6x;
    end

    // watchdog
    initial
    begin
        do
        begin
            @(posedge clk6x);
            cycles++;
        end
        while (cycle_limit == 0 || cycles <= cycle_limit);
        $display("timeout after %0d clock cycles, the tests did not finish", cycles);
        $display("Test failed");
        $finish;
    end

    task automatic check(input string name, input logic [39:0] got, input logic [39:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // expected entry straight from the sampler rules
    function automatic trace_entry_t model_entry(input logic c02, input cpu_addr_t a,
                                                 input cpu_data_t d, input cpu_pins_t p,
                                                 input logic mx_after);
        trace_entry_t e;
        logic         ef_seen;
        ef_seen           = p.ef | c02;
        e.bank            = c02 ? 8'h00 : d;    // C02 has no bank
        e.addr            = a;
        e.data            = d;
        e.status.x_flag   = p.csob_mx | c02 | p.ef;
        e.status.m_flag   = mx_after | c02 | ef_seen;
        e.status.sync_vpa = p.sync_vpa;
        e.status.mln      = p.mln;
        e.status.vpn      = p.vpn;
        e.status.vda      = p.vda | c02;
        e.status.ef       = ef_seen;
        e.status.rwn      = p.rwn;
        return e;
    endfunction

    function automatic cpu_data_t model_byte(input int idx, input int sel);
        trace_entry_t e;
        if (idx >= model_q.size() || sel > 4)
            return TRACE_EMPTY_BYTE;
        e = model_q[idx];
        case (sel)
            0:       return e.status;
            1:       return e.data;
            2:       return e.addr[7:0];
            3:       return e.addr[15:8];
            default: return e.bank;
        endcase
    endfunction

    // one cpu cycle, phases counted from the drop of stopped_o
    task automatic run_cycle(input logic c02, input cpu_addr_t a, input cpu_data_t d,
                             input cpu_pins_t p, input logic mx_after, input logic run);
        cputype02_i = c02;
        cpu_ab_i    = a;
        cd_i        = d;
        pins_i      = p;        // mx shows x before the latch
        run_i       = 1'b1;
        while (stopped_o)
            @(negedge clk6x);
        for (int ph = 0; ph < 6; ph++)
        begin
            if (ph > 0)
                @(negedge clk6x);
            check("cphi2_o", 40'(cphi2_o), 40'(ph >= 3));
            check("stopped_o", 40'(stopped_o), 40'd0);
            if (ph == 4)
            begin
                pins_i.csob_mx = mx_after;  // m between latch and release
                run_i          = run;       // stop request mid cycle
            end
        end
        @(negedge clk6x);
        if (!run)
        begin
            check("stopped_o", 40'(stopped_o), 40'd1);
            check("cphi2_o", 40'(cphi2_o), 40'd0);
        end
        model_q.push_front(model_entry(c02, a, d, p, mx_after));
        if (model_q.size() > TRACE_DEPTH)
            void'(model_q.pop_back());
    endtask

    task automatic read_byte(input int idx, input int sel);
        trace_idx_i      = trace_idx_t'(idx);
        trace_byte_sel_i = byte_sel_t'(sel);
        @(negedge clk6x);       // pending push has landed
        check($sformatf("trace_byte_o[%0d][%0d]", idx, sel), 40'(trace_byte_o),
              40'(model_byte(idx, sel)));
    endtask

    // count, then every stored byte against the model
    task automatic check_count(input int exp);
        @(negedge clk6x);
        check("trace_count_o", 40'(trace_count_o), 40'(exp));
        for (int i = 0; i < model_q.size(); i++)
            for (int s = 0; s < TRACE_BYTES; s++)
                read_byte(i, s);
    endtask

    task automatic clear_trace();
        @(negedge clk6x);
        trace_clr_i = 1'b1;
        @(negedge clk6x);
        trace_clr_i = 1'b0;
        model_q.delete();
    endtask

    initial
    begin
        int                 fd;
        int                 nlines;
        logic [63:0]        op;
        logic [8*128-1:0]   line;
        logic [31:0]        f0;
        logic [31:0]        f1;
        logic [31:0]        f2;
        logic [31:0]        f3;
        logic [31:0]        f4;
        logic [31:0]        f5;
        rst_n_i          = 1'b0;
        run_i            = 1'b0;
        cputype02_i      = 1'b0;
        trace_clr_i      = 1'b0;
        cpu_ab_i         = '0;
        cd_i             = '0;
        pins_i           = '0;
        trace_idx_i      = '0;
        trace_byte_sel_i = '0;
        nlines           = 0;
        fd = $fopen("nora_trace_tests.dat", "r");
        if (fd == 0)
        begin
            $display("could not open nora_trace_tests.dat");
            $display("Test failed");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                void'($fgets(line, fd));
                nlines++;
            end
            $fclose(fd);
            cycle_limit = 8 * nlines + 50;
            repeat (4) @(negedge clk6x);
            rst_n_i = 1'b1;
            check("stopped_o", 40'(stopped_o), 40'd1);      // reset state
            check("cphi2_o", 40'(cphi2_o), 40'd0);
            check("trace_count_o", 40'(trace_count_o), 40'd0);
            fd = $fopen("nora_trace_tests.dat", "r");
            while ($fscanf(fd, "%s", op) == 1)
            begin
                if (op == 64'("cyc"))
                begin
                    void'($fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5));
                    run_cycle(f0[0], f1[15:0], f2[7:0], f3[6:0], f4[0], f5[0]);
                end
                else if (op == 64'("rd"))
                begin
                    void'($fscanf(fd, "%h %h", f0, f1));
                    read_byte(int'(f0), int'(f1));
                end
                else if (op == 64'("cnt"))
                begin
                    void'($fscanf(fd, "%h", f0));
                    check_count(int'(f0));
                end
                else if (op == 64'("clr"))
                    clear_trace();
                else if (op == 64'("#"))
                    void'($fgets(line, fd));    // comment line
                else
                begin
                    errors++;
                    $display("unknown opcode in test file, line skipped");
                    void'($fgets(line, fd));
                end
            end
            $fclose(fd);
            $display("%0d checks, %0d errors", checks, errors);
            if (errors == 0)
                $display("Test completed successfully");
            else
                $display("Test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* phaser_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~
// phaser strobe and cphi2 assertions, bound into phaser
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module phaser_checker (
    input logic clk6x,
    input logic rst_n_i,
    input logic cphi2_o,
    input logic stopped_o,
    input logic latch_ad_o,
    input logic release_wr_o
);
    // address latch only while phi2 is high
    latch_in_phi2: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        latch_ad_o |-> cphi2_o)
        else $error("latch_ad pulsed with cphi2 low");

    // parked clock stays low
    stopped_low: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        stopped_o |-> !cphi2_o)
        else $error("cphi2 high while stopped");

    strobes_apart: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        !(latch_ad_o && release_wr_o))
        else $error("latch_ad and release_wr in the same cycle");

    rise_on_latch: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        $rose(cphi2_o) |-> latch_ad_o)
        else $error("cphi2 rose without latch_ad");

endmodule

bind phaser phaser_checker u_phaser_chk (.*);

`default_nettype wire

/* nora_trace_top.sv */
// ~~~~~~~~~~~~~~~~~~
// top level, phaser + bus sampler + trace buffer
// ~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module nora_trace_top (
    input  logic                    clk6x,
    input  logic                    rst_n_i,
    input  logic                    run_i,              // debugger run/stop
    input  logic                    cputype02_i,        // 1 = 65C02 fitted
    input  cpu_bus_pkg::cpu_addr_t  cpu_ab_i,
    input  cpu_bus_pkg::cpu_data_t  cd_i,
    input  cpu_bus_pkg::cpu_pins_t  pins_i,
    input  logic                    trace_clr_i,
    input  trace_pkg::trace_idx_t   trace_idx_i,
    input  trace_pkg::byte_sel_t    trace_byte_sel_i,
    output logic                    cphi2_o,            // to cpu phi2 pin
    output logic                    stopped_o,
    output cpu_bus_pkg::cpu_data_t  trace_byte_o,
    output trace_pkg::trace_cnt_t   trace_count_o
);
    import trace_pkg::*;

    logic         latch_ad;     // phi2 rising, grab address
    logic         release_wr;   // end of cycle, grab m flag
    logic         push;         // one trace entry per cpu cycle
    trace_entry_t entry;

    phaser u_phaser (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n_i),
        .run_i        (run_i),
        .cphi2_o      (cphi2_o),
        .stopped_o    (stopped_o),
        .latch_ad_o   (latch_ad),
        .release_wr_o (release_wr)
    );

    cpu_bus_sampler u_sampler (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n_i),
        .latch_ad_i   (latch_ad),
        .release_wr_i (release_wr),
        .cputype02_i  (cputype02_i),
        .cpu_ab_i     (cpu_ab_i),
        .cd_i         (cd_i),
        .pins_i       (pins_i),
        .push_o       (push),
        .entry_o      (entry)
    );

    trace_buffer u_trace (
        .clk6x      (clk6x),
        .rst_n_i    (rst_n_i),
        .push_i     (push),
        .clr_i      (trace_clr_i),
        .entry_i    (entry),
        .idx_i      (trace_idx_i),
        .byte_sel_i (trace_byte_sel_i),
        .byte_o     (trace_byte_o),
        .count_o    (trace_count_o)
    );

endmodule

`default_nettype wire

/* trace_buffer.sv */
// ~~~~~~~~~~~~~~~~~~
// circular cpu trace store with fill count, clear and byte readout
// ~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module trace_buffer (
    input  logic                    clk6x,
    input  logic                    rst_n_i,
    input  logic                    push_i,         // store entry_i this clock
    input  logic                    clr_i,          // empty the buffer, wins over push
    input  trace_pkg::trace_entry_t entry_i,
    input  trace_pkg::trace_idx_t   idx_i,          // 0 = newest
    input  trace_pkg::byte_sel_t    byte_sel_i,
    output cpu_bus_pkg::cpu_data_t  byte_o,
    output trace_pkg::trace_cnt_t   count_o
);
    import trace_pkg::*;

    trace_entry_t mem_q [TRACE_DEPTH];  // circular store
    trace_idx_t   wr_ptr_q;             // next slot to write
    trace_cnt_t   count_q;              // valid entries, saturates
    trace_idx_t   rd_ptr;
    trace_entry_t rd_entry;
    logic         rd_valid;

    // pointer and count
    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr_q <= '0;
            count_q  <= '0;
        end
        else if (clr_i)
        begin
            wr_ptr_q <= '0;
            count_q  <= '0;
        end
        else if (push_i)
        begin
            wr_ptr_q <= wr_ptr_q + trace_idx_t'(1);     // wraps, oldest overwritten
            if (count_q < trace_cnt_t'(TRACE_DEPTH))
                count_q <= count_q + trace_cnt_t'(1);
        end
    end

    // entry storage
    always_ff @(posedge clk6x)
    begin
        if (push_i && !clr_i)
            mem_q[wr_ptr_q] <= entry_i;
    end

    // newest sits one below the write pointer
    assign rd_ptr   = wr_ptr_q - trace_idx_t'(1) - idx_i;
    assign rd_entry = mem_q[rd_ptr];
    assign rd_valid = ({1'b0, idx_i} < count_q) &&
                      (byte_sel_i < byte_sel_t'(TRACE_BYTES));

    always_comb
    begin
        byte_o = TRACE_EMPTY_BYTE;      // empty slot or bad select
        if (rd_valid)
        begin
            case (byte_sel_i)
                3'd0:    byte_o = rd_entry.status;
                3'd1:    byte_o = rd_entry.data;
                3'd2:    byte_o = rd_entry.addr[7:0];
                3'd3:    byte_o = rd_entry.addr[15:8];
                3'd4:    byte_o = rd_entry.bank;
                default: byte_o = TRACE_EMPTY_BYTE;
            endcase
        end
    end

    assign count_o = count_q;

endmodule

`default_nettype wire

/* cpu_bus_sampler.sv */
// ~~~~~~~~~~~~~~~~~~
// cpu bus capture at phaser strobes, builds one trace entry per cycle
// ~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module cpu_bus_sampler (
    input  logic                     clk6x,
    input  logic                     rst_n_i,
    input  logic                     latch_ad_i,     // phi2 rise
    input  logic                     release_wr_i,   // last phase of cycle
    input  logic                     cputype02_i,    // board strap, 1 = 65C02
    input  cpu_bus_pkg::cpu_addr_t   cpu_ab_i,
    input  cpu_bus_pkg::cpu_data_t   cd_i,
    input  cpu_bus_pkg::cpu_pins_t   pins_i,
    output logic                     push_o,         // entry complete
    output trace_pkg::trace_entry_t  entry_o
);
    import cpu_bus_pkg::*;

    logic        cputype02_q;   // synced strap
    logic        push_q;
    cpu_addr_t   addr_q;
    cpu_data_t   data_q;
    cpu_bank_t   bank_q;
    cpu_status_t status_q;

    // control side, strap and push strobe
    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            cputype02_q <= 1'b0;
            push_q      <= 1'b0;
        end
        else
        begin
            cputype02_q <= cputype02_i;
            push_q      <= release_wr_i;    // m flag is in by now
        end
    end

    // payload, held until the next latch strobe
    always_ff @(posedge clk6x)
    begin
        if (latch_ad_i)
        begin
            addr_q <= cpu_ab_i;
            data_q <= cd_i;
            if (cputype02_q)
                bank_q <= '0;       // 65C02 has no bank byte
            else
                bank_q <= cd_i;     // 816 drives bank on D while phi2 low
            // mx pin shows x at phi2 rise, emulation mode forces 8 bit
            status_q.x_flag   <= pins_i.csob_mx | cputype02_q | pins_i.ef;
            status_q.sync_vpa <= pins_i.sync_vpa;
            status_q.mln      <= pins_i.mln;
            status_q.vpn      <= pins_i.vpn;
            status_q.vda      <= pins_i.vda | cputype02_q;  // always valid on C02
            status_q.ef       <= pins_i.ef | cputype02_q;   // C02 acts as emulation
            status_q.rwn      <= pins_i.rwn;
        end
        if (release_wr_i)
        begin
            // m shows on mx later in the cycle, uses the latched ef
            status_q.m_flag <= pins_i.csob_mx | cputype02_q | status_q.ef;
        end
    end

    assign push_o         = push_q;
    assign entry_o.bank   = bank_q;
    assign entry_o.addr   = addr_q;
    assign entry_o.data   = data_q;
    assign entry_o.status = status_q;

endmodule

`default_nettype wire

/* phaser.sv */
// ~~~~~~~~~~~~~~~~~~
// cpu clock phaser, run/stop fsm and bus sampling strobes
// ~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module phaser (
    input  logic clk6x,
    input  logic rst_n_i,
    input  logic run_i,         // level, 1 = let the cpu clock run
    output logic cphi2_o,       // cpu phi2, 3 low + 3 high clk6x
    output logic stopped_o,     // cpu clock parked low
    output logic latch_ad_o,    // pulse at phi2 rise
    output logic release_wr_o   // pulse in last phase of the cycle
);
    import cpu_bus_pkg::*;

    typedef enum logic {
        ST_STOPPED,
        ST_RUNNING
    } ph_state_t;

    ph_state_t state_q;
    phase_t    phase_q;     // position inside the cpu cycle
    logic      running;
    logic      last_phase;

    assign running    = (state_q == ST_RUNNING);
    assign last_phase = (phase_q == phase_t'(PHASE_COUNT - 1));

    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q <= ST_STOPPED;
            phase_q <= '0;
        end
        else
        begin
            case (state_q)
                ST_STOPPED:
                begin
                    phase_q <= '0;              // park at start of phi1
                    if (run_i)
                        state_q <= ST_RUNNING;  // first cycle starts at phase 0
                end
                ST_RUNNING:
                begin
                    if (last_phase)
                    begin
                        phase_q <= '0;
                        // stop only on a cycle boundary
                        if (!run_i)
                            state_q <= ST_STOPPED;
                    end
                    else
                        phase_q <= phase_q + phase_t'(1);
                end
                default: state_q <= ST_STOPPED;
            endcase
        end
    end

    // decoded from the state regs, all low while stopped
    assign cphi2_o      = running && (phase_q >= phase_t'(PHASE_LATCH));
    assign latch_ad_o   = running && (phase_q == phase_t'(PHASE_LATCH));
    assign release_wr_o = running && (phase_q == phase_t'(PHASE_RELEASE));
    assign stopped_o    = !running;

endmodule

`default_nettype wire

/* trace_pkg.sv */
// ~~~~~~~~~~~~~~~~~~
// trace entry layout, buffer depth and readout select types
// ~~~~~~~~~~~~~~~~~~
`default_nettype none

package trace_pkg;

    // one traced cpu cycle, 40 bits
    typedef struct packed {
        cpu_bus_pkg::cpu_bank_t   bank;     // readout byte 4
        cpu_bus_pkg::cpu_addr_t   addr;     // bytes 3 (high) and 2 (low)
        cpu_bus_pkg::cpu_data_t   data;     // byte 1
        cpu_bus_pkg::cpu_status_t status;   // byte 0
    } trace_entry_t;

    localparam int unsigned TRACE_DEPTH = 8;    // entries kept
    localparam int unsigned TRACE_BYTES = 5;    // readable bytes per entry

    // entry index for readout, 0 = newest
    typedef logic [$clog2(TRACE_DEPTH)-1:0] trace_idx_t;

    // fill count, one bit wider so a full buffer reads 8
    typedef logic [$clog2(TRACE_DEPTH):0] trace_cnt_t;

    // byte select within an entry
    // 0 status, 1 data, 2 addr lo, 3 addr hi, 4 bank
    typedef logic [2:0] byte_sel_t;

    // value seen by the debugger for an empty slot or bad select
    localparam logic [7:0] TRACE_EMPTY_BYTE = 8'hFF;

endpackage

`default_nettype wire

/* cpu_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~
// 65C02/65C816 bus types, status pin structs and CPHI2 phase constants
// ~~~~~~~~~~~~~~~~~~
`default_nettype none

package cpu_bus_pkg;

    typedef logic [15:0] cpu_addr_t;    // cpu address bus, A15..A0
    typedef logic [7:0]  cpu_data_t;    // cpu data bus byte
    typedef logic [7:0]  cpu_bank_t;    // 65C816 bank, muxed on D7..D0 while phi2 low

    // raw cpu status pins as seen on the board
    typedef struct packed {
        logic csob_mx;      // 6502 SOB, 65C816 M/X flag output
        logic sync_vpa;     // 6502 SYNC, 65C816 VPA
        logic mln;          // memory lock, active low
        logic vpn;          // vector pull, active low
        logic vda;          // valid data address, 816 only
        logic ef;           // emulation flag, 816 only
        logic rwn;          // 1 read, 0 write
    } cpu_pins_t;

    // status byte as stored in the trace, msb first
    typedef struct packed {
        logic x_flag;       // x width, valid at phi2 rise
        logic m_flag;       // m width, valid at phi2 fall
        logic sync_vpa;
        logic mln;
        logic vpn;
        logic vda;
        logic ef;
        logic rwn;
    } cpu_status_t;

    localparam int unsigned PHASE_COUNT   = 6;  // clk6x cycles per cpu cycle
    localparam int unsigned PHASE_LATCH   = 3;  // cphi2 rises here, address latched
    localparam int unsigned PHASE_RELEASE = 5;  // last phase, write released

    typedef logic [2:0] phase_t;        // holds 0..PHASE_COUNT-1

endpackage

`default_nettype wire
